// ==== design/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define WORD_W   16
`define NUM_REGS 4

`define OP_BNE   4'd0
`define OP_BEQ   4'd1
`define OP_BGZ   4'd2
`define OP_BLZ   4'd3
`define OP_ADI   4'd4
`define OP_ORI   4'd5
`define OP_LHI   4'd6
`define OP_LWD   4'd7
`define OP_SWD   4'd8
`define OP_JMP   4'd9
`define OP_JAL   4'd10
`define OP_RTYPE 4'd15 // alu ops, jpr, jrl, wwd, hlt

`define FN_ADD 6'd0
`define FN_SUB 6'd1
`define FN_AND 6'd2
`define FN_ORR 6'd3
`define FN_NOT 6'd4
`define FN_TCP 6'd5
`define FN_SHL 6'd6
`define FN_SHR 6'd7
`define FN_JPR 6'd25
`define FN_JRL 6'd26
`define FN_WWD 6'd28
`define FN_HLT 6'd29

`define ALUOP_ADD  2'b00
`define ALUOP_FUNC 2'b10 // decode by func code
`define ALUOP_OPC  2'b11 // decode by opcode

`endif

// ==== design/cpu_pkg.sv ====
`default_nettype none
`include "cpu_macros.svh"

package cpu_pkg;
	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [3:0] opcode_t;
	typedef logic [5:0] func_t;
	typedef logic [$clog2(`NUM_REGS)-1:0] reg_addr_t;
	typedef logic [7:0] imm_t;
	typedef logic [1:0] pc_src_t; // 0 alu result, 1 alu_out reg, 2 jump target, 3 rs
	typedef logic [1:0] alu_b_t;  // 0 reg B, 1 constant one, 2 extended imm

	typedef enum logic [3:0] {
		st_if, st_id,
		st_memad, st_memr, st_memw, st_wbm,
		st_exr, st_exi, st_wba,
		st_br, st_j, st_jl,
		st_wwd, st_hlt
	} ctrl_state_t;
endpackage

`default_nettype wire

// ==== design/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module control_unit import cpu_pkg::*; (
	input wire clk,
	input wire reset_n,
	input wire opcode_t i_opcode,
	input wire func_t i_func_code,
	output logic o_pc_write,
	output logic o_pc_write_cond,
	output logic o_i_or_d,
	output logic o_mem_read,
	output logic o_mem_write,
	output logic o_ir_write,
	output logic o_mem_to_reg,
	output logic o_pc_to_reg,
	output logic o_reg_write,
	output logic o_alu_src_a,
	output alu_b_t o_alu_src_b,
	output logic [1:0] o_alu_op,
	output pc_src_t o_pc_src,
	output logic o_wwd,
	output logic o_new_inst,
	output logic o_halt,
	output word_t o_num_inst
);
	ctrl_state_t state, next_state;
	logic is_rtype;
	pc_src_t jump_src;

	assign is_rtype = (i_opcode == `OP_RTYPE);
	assign jump_src = is_rtype ? 2'd3 : 2'd2; // jpr/jrl take rs

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= st_if;
			o_num_inst <= '0;
		end else begin
			state <= next_state;
			if (o_new_inst)
				o_num_inst <= o_num_inst + 1'b1;
		end
	end

	always_comb begin
		next_state = st_if;
		case (state)
			st_if: next_state = st_id;
			st_id: begin
				if (i_opcode == `OP_JAL || (is_rtype && i_func_code == `FN_JRL))
					next_state = st_jl;
				else if (i_opcode == `OP_JMP || (is_rtype && i_func_code == `FN_JPR))
					next_state = st_j;
				else if (i_opcode == `OP_BNE || i_opcode == `OP_BEQ ||
						i_opcode == `OP_BGZ || i_opcode == `OP_BLZ)
					next_state = st_br;
				else if (i_opcode == `OP_ADI || i_opcode == `OP_ORI || i_opcode == `OP_LHI)
					next_state = st_exi;
				else if (is_rtype && i_func_code == `FN_WWD)
					next_state = st_wwd;
				else if (is_rtype && i_func_code == `FN_HLT)
					next_state = st_hlt;
				else if (i_opcode == `OP_LWD || i_opcode == `OP_SWD)
					next_state = st_memad;
				else
					next_state = st_exr; // everything else runs as r-type alu
			end
			st_memad: next_state = (i_opcode == `OP_LWD) ? st_memr : st_memw;
			st_memr: next_state = st_wbm;
			st_exr, st_exi: next_state = st_wba;
			st_hlt: next_state = st_hlt; // only reset leaves
			default: next_state = st_if;
		endcase
	end

	always_comb begin
		o_pc_write = 1'b0;
		o_pc_write_cond = 1'b0;
		o_i_or_d = 1'b0;
		o_mem_read = 1'b0;
		o_mem_write = 1'b0;
		o_ir_write = 1'b0;
		o_mem_to_reg = 1'b0;
		o_pc_to_reg = 1'b0;
		o_reg_write = 1'b0;
		o_alu_src_a = 1'b0;
		o_alu_src_b = 2'd0;
		o_alu_op = `ALUOP_ADD;
		o_pc_src = 2'd0;
		o_wwd = 1'b0;
		o_new_inst = 1'b0;
		o_halt = 1'b0;
		case (state)
			st_if: begin
				o_mem_read = 1'b1;
				o_ir_write = 1'b1;
				o_pc_write = 1'b1;
				o_alu_src_b = 2'd1; // pc + 1
			end
			st_id: o_alu_src_b = 2'd2; // branch target into alu_out
			st_memad: begin
				o_alu_src_a = 1'b1;
				o_alu_src_b = 2'd2;
			end
			st_memr: begin
				o_i_or_d = 1'b1;
				o_mem_read = 1'b1;
			end
			st_memw: begin
				o_i_or_d = 1'b1;
				o_mem_write = 1'b1;
				o_new_inst = 1'b1;
			end
			st_wbm: begin
				o_mem_to_reg = 1'b1;
				o_reg_write = 1'b1;
				o_new_inst = 1'b1;
			end
			st_exr: begin
				o_alu_src_a = 1'b1;
				o_alu_op = `ALUOP_FUNC;
			end
			st_exi: begin
				o_alu_src_a = 1'b1;
				o_alu_src_b = 2'd2;
				o_alu_op = `ALUOP_OPC;
			end
			st_wba: begin
				o_reg_write = 1'b1;
				o_new_inst = 1'b1;
			end
			st_br: begin
				o_pc_write_cond = 1'b1;
				o_pc_src = 2'd1; // target computed in id
				o_alu_src_a = 1'b1;
				o_alu_op = `ALUOP_OPC;
				o_new_inst = 1'b1;
			end
			st_j: begin
				o_pc_write = 1'b1;
				o_pc_src = jump_src;
				o_new_inst = 1'b1;
			end
			st_jl: begin
				o_pc_write = 1'b1;
				o_pc_src = jump_src;
				o_pc_to_reg = 1'b1; // link into r2
				o_reg_write = 1'b1;
				o_new_inst = 1'b1;
			end
			st_wwd: begin
				o_wwd = 1'b1;
				o_new_inst = 1'b1;
			end
			st_hlt: o_halt = 1'b1; // hlt itself is not counted
			default: ;
		endcase
	end
endmodule

`default_nettype wire

// ==== design/alu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module alu import cpu_pkg::*; (
	input wire [1:0] i_alu_op,
	input wire opcode_t i_opcode,
	input wire func_t i_func_code,
	input wire word_t i_a,
	input wire word_t i_b,
	output word_t o_result,
	output logic o_bcond
);
	always_comb begin
		o_result = i_a + i_b;
		case (i_alu_op)
			`ALUOP_FUNC: begin
				case (i_func_code)
					`FN_SUB: o_result = i_a - i_b;
					`FN_AND: o_result = i_a & i_b;
					`FN_ORR: o_result = i_a | i_b;
					`FN_NOT: o_result = ~i_a;
					`FN_TCP: o_result = ~i_a + 1'b1;
					`FN_SHL: o_result = i_a << 1;
					`FN_SHR: o_result = word_t'($signed(i_a) >>> 1); // arithmetic
					default: o_result = i_a + i_b;
				endcase
			end
			`ALUOP_OPC: begin
				case (i_opcode)
					`OP_ADI: o_result = i_a + i_b;
					`OP_ORI: o_result = i_a | i_b;
					`OP_LHI: o_result = i_b << 8;
					default: o_result = i_a - i_b; // branch compare
				endcase
			end
			default: o_result = i_a + i_b;
		endcase
	end

	// condition only matters while pc_write_cond is set
	always_comb begin
		case (i_opcode)
			`OP_BNE: o_bcond = (i_a != i_b);
			`OP_BEQ: o_bcond = (i_a == i_b);
			`OP_BGZ: o_bcond = !i_a[`WORD_W-1] && (i_a != '0);
			`OP_BLZ: o_bcond = i_a[`WORD_W-1];
			default: o_bcond = 1'b0;
		endcase
	end
endmodule

`default_nettype wire

// ==== design/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module register_file import cpu_pkg::*; (
	input wire clk,
	input wire reset_n,
	input wire reg_addr_t i_rs,
	input wire reg_addr_t i_rt,
	input wire reg_addr_t i_rd,
	input wire i_write,
	input wire word_t i_wdata,
	output word_t o_rs_data,
	output word_t o_rt_data
);
	word_t regs [`NUM_REGS];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end else if (i_write) begin
			regs[i_rd] <= i_wdata;
		end
	end

	assign o_rs_data = regs[i_rs];
	assign o_rt_data = regs[i_rt];
endmodule

`default_nettype wire

// ==== design/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module datapath import cpu_pkg::*; (
	input wire clk,
	input wire reset_n,
	input wire i_pc_write,
	input wire i_pc_write_cond,
	input wire i_i_or_d,
	input wire i_mem_read,
	input wire i_mem_write,
	input wire i_ir_write,
	input wire i_mem_to_reg,
	input wire i_pc_to_reg,
	input wire i_reg_write,
	input wire i_alu_src_a,
	input wire alu_b_t i_alu_src_b,
	input wire [1:0] i_alu_op,
	input wire pc_src_t i_pc_src,
	input wire i_wwd,
	input wire i_new_inst,
	input wire i_halt,
	input wire word_t i_mem_rdata,
	output opcode_t o_opcode,
	output func_t o_func_code,
	output word_t o_mem_addr,
	output word_t o_mem_wdata,
	output logic o_mem_read,
	output logic o_mem_write,
	output word_t o_output_port
);
	word_t pc, ir, mdr, a_q, b_q, alu_out_q;
	word_t rs_data, rt_data, alu_a, alu_b, alu_result, imm_ext, pc_next, reg_wdata;
	reg_addr_t rs_addr, rt_addr, wr_addr;
	imm_t imm;
	logic bcond;

	assign o_opcode = ir[15:12];
	assign o_func_code = ir[5:0];
	assign rs_addr = ir[11:10];
	assign rt_addr = ir[9:8];
	assign imm = ir[7:0];
	// ori and lhi use the immediate unsigned
	assign imm_ext = (o_opcode == `OP_ORI || o_opcode == `OP_LHI) ?
			word_t'(imm) : word_t'($signed(imm));

	assign alu_a = i_alu_src_a ? a_q : pc;
	always_comb begin
		case (i_alu_src_b)
			2'd1: alu_b = word_t'(1);
			2'd2: alu_b = imm_ext;
			default: alu_b = b_q;
		endcase
		case (i_pc_src)
			2'd1: pc_next = alu_out_q;
			2'd2: pc_next = {pc[`WORD_W-1:12], ir[11:0]};
			2'd3: pc_next = a_q;
			default: pc_next = alu_result;
		endcase
	end

	// links go to r2, r-type writes rd, the rest rt
	assign wr_addr = i_pc_to_reg ? reg_addr_t'(2) :
			(o_opcode == `OP_RTYPE) ? ir[7:6] : rt_addr;
	assign reg_wdata = i_pc_to_reg ? pc : i_mem_to_reg ? mdr : alu_out_q;

	assign o_mem_addr = i_i_or_d ? alu_out_q : pc;
	assign o_mem_wdata = b_q;
	assign o_mem_read = i_mem_read;
	assign o_mem_write = i_mem_write;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
			o_output_port <= '0;
		end else begin
			if (i_pc_write || (i_pc_write_cond && bcond))
				pc <= pc_next;
			if (i_wwd)
				o_output_port <= a_q;
		end
	end

	always_ff @(posedge clk) begin
		if (i_ir_write)
			ir <= i_mem_rdata;
		if (i_mem_read)
			mdr <= i_mem_rdata;
		alu_out_q <= alu_result;
		if (!(i_new_inst || i_halt)) begin // operands hold at retire and halt
			a_q <= rs_data;
			b_q <= rt_data;
		end
	end

	register_file u_register_file (
		.clk(clk),
		.reset_n(reset_n),
		.i_rs(rs_addr),
		.i_rt(rt_addr),
		.i_rd(wr_addr),
		.i_write(i_reg_write),
		.i_wdata(reg_wdata),
		.o_rs_data(rs_data),
		.o_rt_data(rt_data)
	);

	alu u_alu (
		.i_alu_op(i_alu_op),
		.i_opcode(o_opcode),
		.i_func_code(o_func_code),
		.i_a(alu_a),
		.i_b(alu_b),
		.o_result(alu_result),
		.o_bcond(bcond)
	);
endmodule

`default_nettype wire

// ==== design/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu import cpu_pkg::*; (
	input wire clk,
	input wire reset_n,
	input wire word_t i_mem_rdata,
	output word_t o_mem_addr,
	output word_t o_mem_wdata,
	output logic o_mem_read,
	output logic o_mem_write,
	output word_t o_output_port,
	output word_t o_num_inst,
	output logic o_halted
);
	opcode_t opcode;
	func_t func_code;
	logic pc_write, pc_write_cond, i_or_d, mem_read, mem_write, ir_write;
	logic mem_to_reg, pc_to_reg, reg_write, alu_src_a, wwd, new_inst, halt;
	alu_b_t alu_src_b;
	logic [1:0] alu_op;
	pc_src_t pc_src;

	assign o_halted = halt;

	control_unit u_control_unit (
		.clk(clk),
		.reset_n(reset_n),
		.i_opcode(opcode),
		.i_func_code(func_code),
		.o_pc_write(pc_write),
		.o_pc_write_cond(pc_write_cond),
		.o_i_or_d(i_or_d),
		.o_mem_read(mem_read),
		.o_mem_write(mem_write),
		.o_ir_write(ir_write),
		.o_mem_to_reg(mem_to_reg),
		.o_pc_to_reg(pc_to_reg),
		.o_reg_write(reg_write),
		.o_alu_src_a(alu_src_a),
		.o_alu_src_b(alu_src_b),
		.o_alu_op(alu_op),
		.o_pc_src(pc_src),
		.o_wwd(wwd),
		.o_new_inst(new_inst),
		.o_halt(halt),
		.o_num_inst(o_num_inst)
	);

	datapath u_datapath (
		.clk(clk),
		.reset_n(reset_n),
		.i_pc_write(pc_write),
		.i_pc_write_cond(pc_write_cond),
		.i_i_or_d(i_or_d),
		.i_mem_read(mem_read),
		.i_mem_write(mem_write),
		.i_ir_write(ir_write),
		.i_mem_to_reg(mem_to_reg),
		.i_pc_to_reg(pc_to_reg),
		.i_reg_write(reg_write),
		.i_alu_src_a(alu_src_a),
		.i_alu_src_b(alu_src_b),
		.i_alu_op(alu_op),
		.i_pc_src(pc_src),
		.i_wwd(wwd),
		.i_new_inst(new_inst),
		.i_halt(halt),
		.i_mem_rdata(i_mem_rdata),
		.o_opcode(opcode),
		.o_func_code(func_code),
		.o_mem_addr(o_mem_addr),
		.o_mem_wdata(o_mem_wdata),
		.o_mem_read(o_mem_read),
		.o_mem_write(o_mem_write),
		.o_output_port(o_output_port)
	);
endmodule

`default_nettype wire

// ==== testbench/cpu_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_chk import cpu_pkg::*; (
	input wire clk,
	input wire reset_n,
	input wire ctrl_state_t i_state,
	input wire i_mem_read,
	input wire i_mem_write,
	input wire i_reg_write,
	input wire i_halt
);
	mem_strobes: assert property (@(posedge clk) disable iff (!reset_n)
			!(i_mem_read && i_mem_write))
		else $error("memory read and write strobes high together");

	no_write_in_fetch: assert property (@(posedge clk) disable iff (!reset_n)
			!(i_state == st_if && i_reg_write))
		else $error("register write during instruction fetch");

	halt_sticky: assert property (@(posedge clk) disable iff (!reset_n)
			i_halt |=> i_halt)
		else $error("halt dropped without reset");

	legal_state: assert property (@(posedge clk) disable iff (!reset_n)
			i_state inside {st_if, st_id, st_memad, st_memr, st_memw, st_wbm, st_exr,
				st_exi, st_wba, st_br, st_j, st_jl, st_wwd, st_hlt})
		else $error("control state outside the legal encodings");
endmodule

bind control_unit cpu_chk u_cpu_chk (
	.clk(clk),
	.reset_n(reset_n),
	.i_state(state),
	.i_mem_read(o_mem_read),
	.i_mem_write(o_mem_write),
	.i_reg_write(o_reg_write),
	.i_halt(o_halt)
);

`default_nettype wire

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_tb import cpu_pkg::*; ();
	localparam int NUM_GROUPS = 20;
	localparam int DATA_BASE = 64; // data region 0x40..0x7f above the program

	logic clk = 1'b0;
	logic reset_n = 1'b0;
	word_t mem_rdata, mem_addr, mem_wdata, output_port, num_inst, last_port;
	logic mem_read, mem_write, halted;
	word_t image [256];
	word_t mem [256];
	word_t ref_mem [256];
	word_t ref_regs [4];
	word_t wwd_exp [$];
	int group_kind [NUM_GROUPS];
	int group_start [NUM_GROUPS+1];
	int seed = 32'h1d91_988c;
	int errors = 0;
	int cycles = 0;
	int cycle_limit = 1000;
	int prog_len, ref_count;
	int wwd_seen = 0;

	always #5 clk = ~clk;

	cpu u_cpu (
		.clk(clk),
		.reset_n(reset_n),
		.i_mem_rdata(mem_rdata),
		.o_mem_addr(mem_addr),
		.o_mem_wdata(mem_wdata),
		.o_mem_read(mem_read),
		.o_mem_write(mem_write),
		.o_output_port(output_port),
		.o_num_inst(num_inst),
		.o_halted(halted)
	);

	// memory image loads during reset
	assign mem_rdata = reset_n ? mem[mem_addr[7:0]] : '0;
	always @(posedge clk) begin
		if (!reset_n)
			mem <= image;
		else if (mem_write)
			mem[mem_addr[7:0]] <= mem_wdata;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout: processor did not halt within %0d cycles", cycle_limit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	function automatic int rand_below(input int n);
		return ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	function automatic word_t enc_i(input opcode_t op, input int rs, input int rt, input int imm);
		return {op, rs[1:0], rt[1:0], imm[7:0]};
	endfunction

	function automatic word_t enc_r(input int rs, input int rt, input int rd, input func_t fn);
		return {`OP_RTYPE, rs[1:0], rt[1:0], rd[1:0], fn};
	endfunction

	task automatic report_mismatch(input string name, input word_t got, input word_t exp);
		errors++;
		$display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
	endtask

	task automatic build_program();
		int k, pc, tgt, rb;
		for (int g = 0; g < NUM_GROUPS; g++) begin
			k = rand_below(10);
			group_kind[g] = (k > 7) ? 4 : k; // wwd three times as likely
		end
		group_start[0] = 0;
		for (int g = 0; g < NUM_GROUPS; g++)
			group_start[g+1] = group_start[g] + ((group_kind[g] == 7) ? 3 :
					(group_kind[g] == 2 || group_kind[g] == 3) ? 2 : 1);
		prog_len = group_start[NUM_GROUPS] + 1;
		for (int g = 0; g < NUM_GROUPS; g++) begin
			pc = group_start[g];
			tgt = group_start[g + 1 + rand_below(NUM_GROUPS - g)]; // later group or hlt
			rb = rand_below(4);
			case (group_kind[g])
				0: image[pc] = enc_r(rand_below(4), rand_below(4), rand_below(4),
						func_t'(rand_below(8)));
				1: image[pc] = enc_i(opcode_t'(4 + rand_below(3)), rand_below(4),
						rand_below(4), rand_below(256));
				2, 3: begin
					image[pc] = enc_i(`OP_LHI, 0, rb, 0); // zero base
					image[pc+1] = enc_i((group_kind[g] == 2) ? `OP_LWD : `OP_SWD, rb,
							rand_below(4), DATA_BASE + rand_below(64));
				end
				4: image[pc] = enc_r(rand_below(4), 0, 0, `FN_WWD);
				5: image[pc] = enc_i(opcode_t'(rand_below(4)), rand_below(4), rand_below(4),
						tgt - pc - 1);
				6: image[pc] = {(rand_below(2) == 1) ? `OP_JAL : `OP_JMP, 12'(tgt)};
				default: begin
					image[pc] = enc_i(`OP_LHI, 0, rb, 0);
					image[pc+1] = enc_i(`OP_ORI, rb, rb, tgt);
					image[pc+2] = enc_r(rb, 0, 0, (rand_below(2) == 1) ? `FN_JRL : `FN_JPR);
				end
			endcase
		end
		image[prog_len-1] = enc_r(0, 0, 0, `FN_HLT);
	endtask

	// instruction level model of the isa
	task automatic run_model();
		word_t pc, npc, ir, a, b, sx, port;
		logic done;
		pc = '0;
		port = '0;
		done = 1'b0;
		ref_count = 0;
		ref_mem = image;
		ref_regs = '{default: '0};
		for (int steps = 0; steps < 1000 && !done; steps++) begin
			ir = ref_mem[pc[7:0]];
			a = ref_regs[ir[11:10]];
			b = ref_regs[ir[9:8]];
			sx = {{8{ir[7]}}, ir[7:0]};
			npc = pc + 16'd1;
			done = (ir[15:12] == `OP_RTYPE && ir[5:0] == `FN_HLT);
			if (!done)
				ref_count++;
			case (ir[15:12])
				`OP_BNE: if (a != b) npc = npc + sx;
				`OP_BEQ: if (a == b) npc = npc + sx;
				`OP_BGZ: if ($signed(a) > 0) npc = npc + sx;
				`OP_BLZ: if ($signed(a) < 0) npc = npc + sx;
				`OP_ADI: ref_regs[ir[9:8]] = a + sx;
				`OP_ORI: ref_regs[ir[9:8]] = a | {8'h00, ir[7:0]};
				`OP_LHI: ref_regs[ir[9:8]] = {ir[7:0], 8'h00};
				`OP_LWD: ref_regs[ir[9:8]] = ref_mem[8'(a + sx)];
				`OP_SWD: ref_mem[8'(a + sx)] = b;
				`OP_JMP: npc = {npc[15:12], ir[11:0]};
				`OP_JAL: begin
					ref_regs[2] = npc; // link
					npc = {npc[15:12], ir[11:0]};
				end
				`OP_RTYPE: begin
					case (ir[5:0])
						`FN_ADD: ref_regs[ir[7:6]] = a + b;
						`FN_SUB: ref_regs[ir[7:6]] = a - b;
						`FN_AND: ref_regs[ir[7:6]] = a & b;
						`FN_ORR: ref_regs[ir[7:6]] = a | b;
						`FN_NOT: ref_regs[ir[7:6]] = ~a;
						`FN_TCP: ref_regs[ir[7:6]] = 16'h0000 - a;
						`FN_SHL: ref_regs[ir[7:6]] = {a[14:0], 1'b0};
						`FN_SHR: ref_regs[ir[7:6]] = {a[15], a[15:1]};
						`FN_JPR: npc = a;
						`FN_JRL: begin
							ref_regs[2] = npc;
							npc = a; // old rs read before the link lands
						end
						`FN_WWD: begin
							if (a != port)
								wwd_exp.push_back(a); // only visible changes
							port = a;
						end
						default: ;
					endcase
				end
				default: ;
			endcase
			pc = npc;
		end
		if (!done) begin
			errors++;
			$display("reference model never reached HLT");
		end
	endtask

	always @(negedge clk) begin
		if (output_port !== last_port) begin
			if (wwd_seen >= wwd_exp.size()) begin
				errors++;
				$display("output port changed to %h with no WWD value left", output_port);
			end else if (output_port !== wwd_exp[wwd_seen]) begin
				report_mismatch("o_output_port", output_port, wwd_exp[wwd_seen]);
			end
			wwd_seen++;
			last_port = output_port;
		end
	end

	initial begin
		last_port = '0;
		for (int i = 0; i < 256; i++)
			image[i] = {i[7:0] ^ 8'h3c, ~i[7:0]};
		build_program();
		run_model();
		cycle_limit = prog_len * 5 + 80; // worst case 5 cycles each plus reset and tail
		repeat (10) @(negedge clk);
		if (mem_write !== 1'b0)
			report_mismatch("o_mem_write", word_t'(mem_write), '0);
		if (num_inst !== '0)
			report_mismatch("o_num_inst", num_inst, '0);
		reset_n = 1'b1;
		if (mem_read !== 1'b1)
			report_mismatch("o_mem_read", word_t'(mem_read), word_t'(1));
		if (mem_addr !== '0)
			report_mismatch("o_mem_addr", mem_addr, '0);
		while (halted !== 1'b1)
			@(negedge clk);
		if (num_inst !== 16'(ref_count))
			report_mismatch("o_num_inst", num_inst, 16'(ref_count));
		repeat (20) begin
			@(negedge clk);
			if (mem_read !== 1'b0 || mem_write !== 1'b0) begin
				errors++;
				$display("memory access at %0t while halted", $time);
			end
		end
		for (int i = 0; i < 256; i++)
			if (mem[i] !== ref_mem[i])
				report_mismatch($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
		if (wwd_seen != wwd_exp.size()) begin
			errors++;
			$display("saw %0d output port changes, model expects %0d", wwd_seen, wwd_exp.size());
		end
		$display("errors %0d, port changes %0d, retired %0d, program words %0d",
				errors, wwd_seen, ref_count, prog_len);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end
endmodule

`default_nettype wire

// ==== cpu.f ====
+incdir+design
design/cpu_pkg.sv
design/control_unit.sv
design/alu.sv
design/register_file.sv
design/datapath.sv
design/cpu.sv
testbench/cpu_chk.sv
testbench/cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= cpu_tb
FILELIST ?= cpu.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST)) design/cpu_macros.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "no verdict in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
